// File: vcr_settings.svh
// ======================================
// virtual-channel router configuration
// port count, VC count, buffer depth and
// payload width shared by all blocks
// ======================================

`ifndef VCR_SETTINGS_SVH
`define VCR_SETTINGS_SVH

// router ports, all ports are alike
`define VCR_NUM_PORTS  4
// virtual channels per port
`define VCR_NUM_VC     2
// flits held by each VC buffer
`define VCR_VC_DEPTH   2
// payload bits per flit
`define VCR_DATA_WIDTH 16

`endif

// File: vcr_pkg.sv
// ======================================
// virtual-channel router types
// flit layout and port / VC index types
// ======================================

`include "vcr_settings.svh"

package vcr_pkg;

  // index of a router port
  typedef logic [$clog2(`VCR_NUM_PORTS)-1:0] port_id_t;

  // index of a virtual channel
  typedef logic [$clog2(`VCR_NUM_VC)-1:0] vc_id_t;

  // one bit per port
  typedef logic [`VCR_NUM_PORTS-1:0] port_oh_t;

  // one bit per VC
  typedef logic [`VCR_NUM_VC-1:0] vc_oh_t;

  // single-flit packet, the header names the output port directly
  typedef struct packed {
    port_id_t                  dst;
    vc_id_t                    vc;
    logic [`VCR_DATA_WIDTH-1:0] payload;
  } flit_t;

endpackage

// File: vcr_rr_arbiter.sv
// ======================================
// round-robin arbiter
// priority rotates past the last grant
// that was actually accepted
// ======================================

`timescale 1ns/1ps

module vcr_rr_arbiter #(
  parameter int NUM_REQ = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [NUM_REQ-1:0] req_i,
  input  logic               accept_i,
  output logic               grant_v_o,
  output logic [NUM_REQ-1:0] grant_oh_o
);

  localparam int PW = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  // index with the highest priority this cycle
  logic [PW-1:0] ptr_q;
  logic [PW-1:0] grant_idx;
  logic [PW-1:0] ptr_next;

  // fixed priority search starting at the pointer
  always_comb begin
    int cand;
    grant_v_o  = 1'b0;
    grant_oh_o = '0;
    grant_idx  = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      cand = (int'(ptr_q) + i) % NUM_REQ;
      if (!grant_v_o && req_i[cand]) begin
        grant_v_o        = 1'b1;
        grant_oh_o[cand] = 1'b1;
        grant_idx        = PW'(cand);
      end
    end
  end

  assign ptr_next = (int'(grant_idx) == NUM_REQ - 1) ? '0 : grant_idx + 1'b1;

  // a refused grant keeps its priority
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (accept_i && grant_v_o) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// File: vcr_input_port.sv
// ======================================
// router input port
// one circular buffer per VC, head flits
// to allocation, credit back on each pop
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_input_port import vcr_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     data_v_i,
  input  flit_t                    data_i,
  input  logic                     pop_i,
  input  vc_oh_t                   pop_vc_i,
  output vc_oh_t                   head_v_o,
  output flit_t [`VCR_NUM_VC-1:0]  head_flit_o,
  output logic                     credit_v_o,
  output vc_id_t                   credit_id_o
);

  localparam int PTR_W = (`VCR_VC_DEPTH > 1) ? $clog2(`VCR_VC_DEPTH) : 1;
  localparam int CNT_W = $clog2(`VCR_VC_DEPTH + 1);

  // ======================================
  // VC buffers
  // ======================================

  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_vc
    flit_t            mem_q [`VCR_VC_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             wr_en;
    logic             rd_en;

    // the vc field of an incoming flit selects its buffer
    assign wr_en = data_v_i && (data_i.vc == vc_id_t'(v)) &&
                   (cnt_q != CNT_W'(`VCR_VC_DEPTH));
    assign rd_en = pop_i && pop_vc_i[v] && (cnt_q != '0);

    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        mem_q[wr_ptr_q] <= data_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr_q <= (int'(wr_ptr_q) == `VCR_VC_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
        end
        if (rd_en) begin
          rd_ptr_q <= (int'(rd_ptr_q) == `VCR_VC_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
        end
        case ({wr_en, rd_en})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    assign head_v_o[v]    = (cnt_q != '0);
    assign head_flit_o[v] = mem_q[rd_ptr_q];
  end

  // ======================================
  // credit return
  // ======================================

  // slot freed in the same cycle as the pop
  assign credit_v_o = pop_i && |(pop_vc_i & head_v_o);

  always_comb begin
    credit_id_o = '0;
    for (int v = 0; v < `VCR_NUM_VC; v++) begin
      if (pop_vc_i[v]) begin
        credit_id_o = vc_id_t'(v);
      end
    end
  end

endmodule

// File: vcr_switch_alloc.sv
// ======================================
// two-level switch allocator
// local VC pick per input, then one
// input granted per output with credits
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_switch_alloc import vcr_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  vc_oh_t   [`VCR_NUM_PORTS-1:0]                head_v_i,
  input  port_id_t [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0] head_dst_i,
  input  port_oh_t                                     vc_avail_i,
  output port_oh_t                                     pop_o,
  output vc_oh_t   [`VCR_NUM_PORTS-1:0]                pop_vc_o,
  output port_oh_t                                     grant_v_o,
  output port_oh_t [`VCR_NUM_PORTS-1:0]                grant_in_o
);

  vc_oh_t   [`VCR_NUM_PORTS-1:0] local_req;
  vc_oh_t   [`VCR_NUM_PORTS-1:0] local_oh;
  port_oh_t                      local_v;
  port_id_t [`VCR_NUM_PORTS-1:0] local_dst;
  // requests seen by each output, one bit per input
  port_oh_t [`VCR_NUM_PORTS-1:0] out_req;

  // ======================================
  // local SA, one arbiter per input
  // ======================================

  // heads whose output has no credit stay out, so they block only their own VC
  always_comb begin
    for (int p = 0; p < `VCR_NUM_PORTS; p++) begin
      for (int v = 0; v < `VCR_NUM_VC; v++) begin
        local_req[p][v] = head_v_i[p][v] && vc_avail_i[head_dst_i[p][v]];
      end
    end
  end

  for (genvar p = 0; p < `VCR_NUM_PORTS; p++) begin : gen_sa_local
    vcr_rr_arbiter #(
      .NUM_REQ    (`VCR_NUM_VC)
    ) i_arb (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (local_req[p]),
      .accept_i   (pop_o[p]),
      .grant_v_o  (local_v[p]),
      .grant_oh_o (local_oh[p])
    );
  end

  // destination of each local winner, turned into per-output requests
  always_comb begin
    local_dst = '0;
    out_req   = '0;
    for (int p = 0; p < `VCR_NUM_PORTS; p++) begin
      for (int v = 0; v < `VCR_NUM_VC; v++) begin
        if (local_oh[p][v]) begin
          local_dst[p] = head_dst_i[p][v];
        end
      end
      for (int o = 0; o < `VCR_NUM_PORTS; o++) begin
        out_req[o][p] = local_v[p] && (local_dst[p] == port_id_t'(o));
      end
    end
  end

  // ======================================
  // global SA, one arbiter per output
  // ======================================

  for (genvar o = 0; o < `VCR_NUM_PORTS; o++) begin : gen_sa_global
    vcr_rr_arbiter #(
      .NUM_REQ    (`VCR_NUM_PORTS)
    ) i_arb (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (out_req[o] & {`VCR_NUM_PORTS{vc_avail_i[o]}}),
      .accept_i   (grant_v_o[o]),
      .grant_v_o  (grant_v_o[o]),
      .grant_oh_o (grant_in_o[o])
    );
  end

  // an input pops when it wins at any output
  always_comb begin
    pop_o = '0;
    for (int p = 0; p < `VCR_NUM_PORTS; p++) begin
      for (int o = 0; o < `VCR_NUM_PORTS; o++) begin
        pop_o[p] = pop_o[p] | grant_in_o[o][p];
      end
      pop_vc_o[p] = pop_o[p] ? local_oh[p] : '0;
    end
  end

endmodule

// File: vcr_out_credits.sv
// ======================================
// output credit unit
// tracks downstream VC slots and picks
// the lowest VC that still has credit
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_out_credits import vcr_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   credit_v_i,
  input  vc_id_t credit_id_i,
  input  logic   consume_i,
  output logic   vc_avail_o,
  output vc_id_t sel_vc_o
);

  localparam int CNT_W = $clog2(`VCR_VC_DEPTH + 1);

  vc_oh_t has_credit;

  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_cnt
    logic [CNT_W-1:0] cnt_q;
    logic             inc;
    logic             dec;

    assign inc = credit_v_i && (credit_id_i == vc_id_t'(v));
    assign dec = consume_i && has_credit[v] && (sel_vc_o == vc_id_t'(v));

    // return and grant in one cycle cancel out
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q <= CNT_W'(`VCR_VC_DEPTH);
      end else begin
        case ({inc, dec})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    assign has_credit[v] = (cnt_q != '0);
  end

  assign vc_avail_o = |has_credit;

  // lowest index wins
  always_comb begin
    sel_vc_o = '0;
    for (int v = `VCR_NUM_VC - 1; v >= 0; v--) begin
      if (has_credit[v]) begin
        sel_vc_o = vc_id_t'(v);
      end
    end
  end

endmodule

// File: vcr_switch.sv
// ======================================
// switch traversal
// crossbar from granted head flits to
// outputs behind the SA-to-ST register
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_switch import vcr_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  flit_t    [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0] head_flit_i,
  input  vc_oh_t   [`VCR_NUM_PORTS-1:0]             pop_vc_i,
  input  port_oh_t                                  grant_v_i,
  input  port_oh_t [`VCR_NUM_PORTS-1:0]             grant_in_i,
  input  vc_id_t   [`VCR_NUM_PORTS-1:0]             sel_vc_i,
  output port_oh_t                                  data_v_o,
  output flit_t    [`VCR_NUM_PORTS-1:0]             data_o
);

  flit_t [`VCR_NUM_PORTS-1:0] xbar_flit;

  // grant and VC pick are one-hot, so a plain select is enough
  always_comb begin
    xbar_flit = '0;
    for (int o = 0; o < `VCR_NUM_PORTS; o++) begin
      for (int i = 0; i < `VCR_NUM_PORTS; i++) begin
        for (int v = 0; v < `VCR_NUM_VC; v++) begin
          if (grant_in_i[o][i] && pop_vc_i[i][v]) begin
            xbar_flit[o] = head_flit_i[i][v];
          end
        end
      end
      // downstream VC replaces the input VC
      xbar_flit[o].vc = sel_vc_i[o];
    end
  end

  // ======================================
  // ST stage register
  // ======================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= grant_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `VCR_NUM_PORTS; o++) begin
      if (grant_v_i[o]) begin
        data_o[o] <= xbar_flit[o];
      end
    end
  end

endmodule

// File: vcr_router.sv
// ======================================
// virtual-channel router top level
// input buffers, switch allocation,
// output credits and crossbar
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_router import vcr_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  port_oh_t                      data_v_i,
  input  flit_t  [`VCR_NUM_PORTS-1:0]   data_i,
  output port_oh_t                      credit_v_o,
  output vc_id_t [`VCR_NUM_PORTS-1:0]   credit_id_o,
  output port_oh_t                      data_v_o,
  output flit_t  [`VCR_NUM_PORTS-1:0]   data_o,
  input  port_oh_t                      credit_v_i,
  input  vc_id_t [`VCR_NUM_PORTS-1:0]   credit_id_i
);

  vc_oh_t   [`VCR_NUM_PORTS-1:0]                   head_v;
  flit_t    [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]  head_flit;
  port_id_t [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]  head_dst;
  port_oh_t                                        vc_avail;
  vc_id_t   [`VCR_NUM_PORTS-1:0]                   sel_vc;
  port_oh_t                                        pop;
  vc_oh_t   [`VCR_NUM_PORTS-1:0]                   pop_vc;
  port_oh_t                                        grant_v;
  port_oh_t [`VCR_NUM_PORTS-1:0]                   grant_in;

  // ======================================
  // input ports and output credit units
  // ======================================

  for (genvar p = 0; p < `VCR_NUM_PORTS; p++) begin : gen_port
    vcr_input_port i_input_port (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .pop_i       (pop[p]),
      .pop_vc_i    (pop_vc[p]),
      .head_v_o    (head_v[p]),
      .head_flit_o (head_flit[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p])
    );

    // only the header's output port goes to allocation
    for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_dst
      assign head_dst[p][v] = head_flit[p][v].dst;
    end

    vcr_out_credits i_out_credits (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .credit_v_i  (credit_v_i[p]),
      .credit_id_i (credit_id_i[p]),
      .consume_i   (grant_v[p]),
      .vc_avail_o  (vc_avail[p]),
      .sel_vc_o    (sel_vc[p])
    );
  end

  // ======================================
  // SA stage and ST stage
  // ======================================

  vcr_switch_alloc i_switch_alloc (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .head_v_i   (head_v),
    .head_dst_i (head_dst),
    .vc_avail_i (vc_avail),
    .pop_o      (pop),
    .pop_vc_o   (pop_vc),
    .grant_v_o  (grant_v),
    .grant_in_o (grant_in)
  );

  vcr_switch i_switch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .head_flit_i (head_flit),
    .pop_vc_i    (pop_vc),
    .grant_v_i   (grant_v),
    .grant_in_i  (grant_in),
    .sel_vc_i    (sel_vc),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

endmodule

// File: vcr_assertions.sv
// ======================================
// router output checks
// credit ids in range, no unknown flit
// data while an output is valid
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module vcr_assertions import vcr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  port_oh_t                     credit_v_o,
  input  vc_id_t [`VCR_NUM_PORTS-1:0]  credit_id_o,
  input  port_oh_t                     data_v_o,
  input  flit_t  [`VCR_NUM_PORTS-1:0]  data_o
);

  // number of assertion failures seen so far
  int fail_count = 0;

  valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown({credit_v_o, data_v_o}))
  else begin
    fail_count++;
    $error("credit or data valid flags are unknown");
  end

  for (genvar p = 0; p < `VCR_NUM_PORTS; p++) begin : gen_port
    credit_id_range: assert property (@(posedge clk_i) disable iff (rst_i)
      credit_v_o[p] |-> (!$isunknown(credit_id_o[p]) && (credit_id_o[p] < `VCR_NUM_VC)))
    else begin
      fail_count++;
      $error("credit id %0d unknown or out of range on port %0d", credit_id_o[p], p);
    end

    data_known: assert property (@(posedge clk_i) disable iff (rst_i)
      data_v_o[p] |-> !$isunknown(data_o[p]))
    else begin
      fail_count++;
      $error("unknown flit on output %0d while valid", p);
    end
  end

endmodule

bind vcr_router vcr_assertions i_assertions (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .credit_v_o  (credit_v_o),
  .credit_id_o (credit_id_o),
  .data_v_o    (data_v_o),
  .data_o      (data_o)
);

// File: tb_vcr_router.sv
// ======================================
// testbench for the VC router
// directed tests with credit models on
// both sides and a per-flow scoreboard
// ======================================

`timescale 1ns/1ps

`include "vcr_settings.svh"

module tb_vcr_router import vcr_pkg::*; ();

  localparam int NP          = `VCR_NUM_PORTS;
  localparam int NV          = `VCR_NUM_VC;
  localparam int DEPTH       = `VCR_VC_DEPTH;
  localparam int DW          = `VCR_DATA_WIDTH;
  localparam int PW          = $bits(port_id_t);
  localparam int VW          = $bits(vc_id_t);
  localparam int SEQ_W       = DW - PW - VW;
  localparam int CLK_PERIOD  = 100;
  localparam int RAND_CYCLES = 200;
  // idle, single, contention, back-pressure, random, each with its waits
  localparam int TEST_CYCLES = 20 + 61 + 101 + 142 + (RAND_CYCLES + 301);
  localparam int WATCHDOG_CYCLES = 10 + TEST_CYCLES + 200;

  logic                        clk_i;
  logic                        rst_i;
  port_oh_t                    data_v_i;
  flit_t  [NP-1:0]             data_i;
  port_oh_t                    credit_v_o;
  vc_id_t [NP-1:0]             credit_id_o;
  port_oh_t                    data_v_o;
  flit_t  [NP-1:0]             data_o;
  port_oh_t                    credit_v_i;
  vc_id_t [NP-1:0]             credit_id_i;

  int            cyc;
  int            errors;
  int            tests;
  int            seq;
  int            last_send;
  int            up_cred [NP][NV];
  int            ds_occ  [NP][NV];
  int            ds_delay;
  port_oh_t      ds_hold;
  logic [DW-1:0] sb_q [NP*NV*NP][$];
  int            sb_pending;
  int            arr_src [NP][$];
  int            arr_vc  [NP][$];
  int            arr_cyc [NP][$];
  int            cred_vc [NP][$];
  int            cred_cyc [NP][$];
  int            ret_due [NP][$];
  int            ret_vc  [NP][$];
  port_oh_t      stg_v;
  flit_t [NP-1:0] stg_f;
  logic [31:0]   rng;

  vcr_router vcr_router_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ======================================
  // helpers
  // ======================================

  task automatic report_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int flow_index(input int src, input int ivc, input int dst);
    return (src * NV + ivc) * NP + dst;
  endfunction

  // payload carries source port and input VC so the flow can be found on arrival
  task automatic stage_flit(input int p, input int v, input int d);
    stg_v[p]         = 1'b1;
    stg_f[p].dst     = port_id_t'(d);
    stg_f[p].vc      = vc_id_t'(v);
    stg_f[p].payload = {port_id_t'(p), vc_id_t'(v), SEQ_W'(seq)};
    seq++;
  endtask

  task automatic send_staged();
    @(posedge clk_i);
    for (int p = 0; p < NP; p++) begin
      if (stg_v[p]) begin
        up_cred[p][stg_f[p].vc]--;
        sb_q[flow_index(p, stg_f[p].vc, stg_f[p].dst)].push_back(stg_f[p].payload);
        sb_pending++;
      end
    end
    data_v_i  <= stg_v;
    data_i    <= stg_f;
    last_send  = cyc;
    stg_v      = '0;
  endtask

  task automatic quiet(input int n);
    repeat (n) begin
      @(posedge clk_i);
      data_v_i <= '0;
    end
  endtask

  task automatic clear_logs();
    for (int o = 0; o < NP; o++) begin
      arr_src[o].delete();
      arr_vc[o].delete();
      arr_cyc[o].delete();
      cred_vc[o].delete();
      cred_cyc[o].delete();
    end
  endtask

  function automatic bit drained();
    bit idle;
    idle = (sb_pending == 0);
    for (int o = 0; o < NP; o++) begin
      if (ret_due[o].size() != 0) idle = 1'b0;
      for (int v = 0; v < NV; v++) begin
        if (up_cred[o][v] != DEPTH) idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic settle(input int limit);
    int waited;
    waited = 0;
    while (!drained() && waited < limit) begin
      @(posedge clk_i);
      waited++;
    end
    assert (drained()) else begin
      $display("traffic did not drain within %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic wait_arrivals(input int o, input int n, input int limit);
    int waited;
    waited = 0;
    while (arr_src[o].size() < n && waited < limit) begin
      @(posedge clk_i);
      waited++;
    end
    assert (arr_src[o].size() >= n) else begin
      $display("timed out waiting for %0d flits at output %0d", n, o);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  // ======================================
  // output monitor and downstream model
  // ======================================

  task automatic record_arrival(input int o, input flit_t f);
    int src;
    int ivc;
    int idx;
    src = int'(f.payload[DW-1 -: PW]);
    ivc = int'(f.payload[DW-PW-1 -: VW]);
    idx = flow_index(src, ivc, o);
    arr_src[o].push_back(src);
    arr_vc[o].push_back(int'(f.vc));
    arr_cyc[o].push_back(cyc);
    ds_occ[o][f.vc]++;
    ret_due[o].push_back(cyc + ds_delay);
    ret_vc[o].push_back(int'(f.vc));
    assert (ds_occ[o][f.vc] <= DEPTH)
      else report_error($sformatf("output %0d overran downstream vc %0d", o, f.vc));
    assert (int'(f.dst) == o)
      else report_error($sformatf("flit for port %0d left on output %0d", f.dst, o));
    assert (sb_q[idx].size() > 0)
      else report_error($sformatf("unexpected flit %h at output %0d", f.payload, o));
    if (sb_q[idx].size() > 0) begin
      assert (sb_q[idx][0] == f.payload) else report_error($sformatf(
        "output %0d payload %h, expected %h", o, f.payload, sb_q[idx][0]));
      void'(sb_q[idx].pop_front());
      sb_pending--;
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int p = 0; p < NP; p++) begin
        if (credit_v_o[p]) begin
          cred_vc[p].push_back(int'(credit_id_o[p]));
          cred_cyc[p].push_back(cyc);
          up_cred[p][credit_id_o[p]]++;
          assert (up_cred[p][credit_id_o[p]] <= DEPTH)
            else report_error($sformatf("extra credit on input %0d", p));
        end
        if (data_v_o[p]) record_arrival(p, data_o[p]);
      end
    end
    cyc++;
  end

  // one returned credit per output per cycle, once its delay has passed
  always @(posedge clk_i) begin
    for (int o = 0; o < NP; o++) begin
      credit_v_i[o] <= 1'b0;
      if (!rst_i && !ds_hold[o] && ret_due[o].size() > 0 && ret_due[o][0] <= cyc) begin
        credit_v_i[o]  <= 1'b1;
        credit_id_i[o] <= vc_id_t'(ret_vc[o][0]);
        ds_occ[o][ret_vc[o][0]]--;
        void'(ret_due[o].pop_front());
        void'(ret_vc[o].pop_front());
      end
    end
  end

  // ======================================
  // directed tests
  // ======================================

  task automatic test_reset_idle();
    int err0;
    err0 = errors;
    repeat (20) begin
      @(negedge clk_i);
      assert (credit_v_o === '0 && data_v_o === '0)
        else report_error("output activity while idle after reset");
    end
    finish_test("reset_idle", err0);
  endtask

  task automatic test_single_flits();
    int err0;
    int t;
    int o;
    err0 = errors;
    clear_logs();
    ds_delay = 1;
    for (int p = 0; p < NP; p++) stage_flit(p, p % NV, (p + 1) % NP);
    send_staged();
    t = last_send;
    quiet(1);
    for (int i = 0; i < NP; i++) wait_arrivals(i, 1, 20);
    settle(40);
    for (int p = 0; p < NP; p++) begin
      o = (p + 1) % NP;
      assert (arr_src[o].size() == 1 && arr_src[o][0] == p && arr_vc[o][0] == 0 &&
              arr_cyc[o][0] == t + 2)
        else report_error($sformatf("flit from input %0d wrong at output %0d", p, o));
      assert (cred_vc[p].size() == 1 && cred_vc[p][0] == p % NV && cred_cyc[p][0] == t + 1)
        else report_error($sformatf("credit return wrong on input %0d", p));
    end
    finish_test("single_flits", err0);
  endtask

  task automatic test_contention();
    int err0;
    port_oh_t seen;
    err0 = errors;
    clear_logs();
    ds_delay = 3;
    seen     = '0;
    for (int p = 0; p < NP; p++) stage_flit(p, 0, 0);
    send_staged();
    quiet(1);
    wait_arrivals(0, NP, 40);
    settle(60);
    for (int i = 0; i < NP && i < arr_src[0].size(); i++) seen[arr_src[0][i]] = 1'b1;
    assert (seen == '1) else report_error("first flits at output 0 miss an input");
    finish_test("contention", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    err0 = errors;
    clear_logs();
    ds_delay   = 2;
    ds_hold[1] = 1'b1;
    for (int v = 0; v < NV; v++) begin
      for (int p = 0; p < NP; p++) stage_flit(p, v, 1);
      send_staged();
    end
    quiet(20);
    assert (arr_vc[1].size() == NV * DEPTH) else report_error($sformatf(
      "%0d flits passed a blocked output, expected %0d", arr_vc[1].size(), NV * DEPTH));
    for (int i = 0; i < arr_vc[1].size(); i++) begin
      assert (arr_vc[1][i] == i / DEPTH)
        else report_error($sformatf("flit %0d took vc %0d under back-pressure", i, arr_vc[1][i]));
    end
    @(negedge clk_i);
    ds_hold[1] = 1'b0;
    wait_arrivals(1, NP * NV, 60);
    settle(60);
    finish_test("backpressure", err0);
  endtask

  task automatic test_random_traffic();
    int err0;
    int v;
    int d;
    err0 = errors;
    clear_logs();
    ds_delay = 4;
    repeat (RAND_CYCLES) begin
      for (int p = 0; p < NP; p++) begin
        rng = xorshift32(rng);
        v   = int'(rng[7:4]) % NV;
        d   = int'(rng[11:8]) % NP;
        if (rng[0] && up_cred[p][v] > 0) stage_flit(p, v, d);
      end
      send_staged();
    end
    quiet(1);
    settle(300);
    assert (sb_pending == 0) else report_error($sformatf("%0d flits never arrived", sb_pending));
    finish_test("random_traffic", err0);
  endtask

  initial begin
    rst_i       = 1'b1;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    cyc         = 0;
    errors      = 0;
    tests       = 0;
    seq         = 0;
    sb_pending  = 0;
    ds_delay    = 1;
    ds_hold     = '0;
    stg_v       = '0;
    stg_f       = '0;
    rng         = 32'hf1ce3098;
    for (int p = 0; p < NP; p++) begin
      for (int v = 0; v < NV; v++) begin
        up_cred[p][v] = DEPTH;
        ds_occ[p][v]  = 0;
      end
    end
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset_idle();
    test_single_flits();
    test_contention();
    test_backpressure();
    test_random_traffic();
    errors += vcr_router_i.i_assertions.fail_count;
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+.
vcr_pkg.sv
vcr_rr_arbiter.sv
vcr_input_port.sv
vcr_switch_alloc.sv
vcr_out_credits.sv
vcr_switch.sv
vcr_router.sv
vcr_assertions.sv
tb_vcr_router.sv
